//--- verification/memory_stimulus.txt
# kind address(hex) length data(hex) expected(hex)
# store writes the low bytes of data; both fetches the data word and loads the expected value
store 00100 4 a1b2c3d4 00000000
load  00100 4 00000000 a1b2c3d4
load  00100 1 00000000 000000d4
load  00101 2 00000000 0000b2c3
store 00202 2 5a5a1234 00000000
load  00200 4 00000000 12340000
store 00207 1 000000ee 00000000
fetch 00204 4 00000000 ee000000
store 00300 4 13579bdf 00000000
fetch 00300 4 00000000 13579bdf
both  00100 2 a1b2c3d4 0000c3d4
store 00101 1 00000077 00000000
load  00100 4 00000000 a1b277d4
both  00300 1 13579bdf 000000df
store 1fff0 4 deadbeef 00000000
load  1fff2 2 00000000 0000dead
fetch 1fff0 4 00000000 deadbeef
load  00400 4 00000000 00000000

//--- project.f
+incdir+include
design/memBusPkg.sv
design/memCtrlPkg.sv
design/requestArbiter.sv
design/byteSequencer.sv
design/byteRam.sv
design/wordAssembler.sv
design/memSubsystem.sv
verification/tbMemSubsystem.sv

//--- run.sh
#!/bin/sh
# build and run the memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tbMemSubsystem \
    -f project.f \
    -o simMemSubsystem

./obj_dir/simMemSubsystem > sim.log 2>&1
cat sim.log

if grep -qF '** FAIL **' sim.log; then
    exit 1
fi
exit 0

//--- verification/tbMemSubsystem.sv
`default_nettype none
`timescale 1ns/100ps

`include "mem_consts.svh"

module tbMemSubsystem;

    localparam int resetCycles = 16;
    localparam int cyclesPerOp = 40;

    logic            clk;
    logic            rst;
    logic            fetchReq;
    memBusPkg::addrT fetchAddr;
    logic            dataReq;
    logic            dataWrite;
    memBusPkg::lenT  dataLen;
    memBusPkg::addrT dataAddr;
    memBusPkg::wordT dataWdata;
    logic            ioBufferFull;
    logic            fetchDone;
    memBusPkg::wordT fetchInst;
    logic            dataDone;
    memBusPkg::wordT dataRdata;
    logic            busy;

    // op codes 0 fetch, 1 load, 2 store, 3 both
    int              opCode [$];
    int              opAddr [$];
    int              opLen [$];
    logic [31:0]     opData [$];
    logic [31:0]     opExpect [$];
    memBusPkg::byteT modelMem [`MEM_DEPTH];
    int              seed = 95579;
    int              errorCount;
    int              checkCount;
    int              cycleCount;
    int              timeoutLimit;

    memSubsystem i_dut (
        .clk(clk), .rst(rst),
        .fetchReq(fetchReq), .fetchAddr(fetchAddr),
        .dataReq(dataReq), .dataWrite(dataWrite), .dataLen(dataLen),
        .dataAddr(dataAddr), .dataWdata(dataWdata),
        .ioBufferFull(ioBufferFull),
        .fetchDone(fetchDone), .fetchInst(fetchInst),
        .dataDone(dataDone), .dataRdata(dataRdata),
        .busy(busy)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > timeoutLimit) begin
            $display("timeout: the run did not finish within %0d cycles", timeoutLimit);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic check(string name, logic [31:0] actual, logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic reportFailure(string msg);
        errorCount++;
        $display("%0t ns: %s", $time, msg);
    endtask

    function automatic logic [31:0] readModel(int addr, int len);
        logic [31:0] value;
        value = '0;
        for (int k = 0; k < len; k++) begin
            value[8*k +: 8] = modelMem[(addr + k) % `MEM_DEPTH];
        end
        return value;
    endfunction

    task automatic writeModel(int addr, int len, logic [31:0] value);
        for (int k = 0; k < len; k++) begin
            modelMem[(addr + k) % `MEM_DEPTH] = value[8*k +: 8];
        end
    endtask

    task automatic loadStimulus();
        int             fd;
        int             code;
        int             addr;
        int             len;
        string          line;
        logic [63:0]    kindText;
        logic [31:0]    value;
        logic [31:0]    expected;
        fd = $fopen("verification/memory_stimulus.txt", "r");
        if (fd == 0) begin
            reportFailure("cannot open verification/memory_stimulus.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    if ($sscanf(line, "%s %h %d %h %h", kindText, addr, len, value,
                            expected) != 5) begin
                        reportFailure("malformed line in the stimulus file");
                    end else begin
                        code = -1;
                        if (kindText == 64'("fetch")) code = 0;
                        if (kindText == 64'("load")) code = 1;
                        if (kindText == 64'("store")) code = 2;
                        if (kindText == 64'("both")) code = 3;
                        if (code < 0) begin
                            reportFailure("unknown operation kind in the stimulus file");
                        end else begin
                            opCode.push_back(code);
                            opAddr.push_back(addr);
                            opLen.push_back(len);
                            opData.push_back(value);
                            opExpect.push_back(expected);
                        end
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic runOp(int idx);
        logic        isFetch;
        logic        isData;
        logic        isStore;
        int          addr;
        int          len;
        int          gap;
        int          stallLen;
        int          nominal;
        int          elapsed;
        int          fetchAt;
        int          dataAt;
        logic [31:0] fetchModel;
        logic [31:0] dataModel;
        addr     = opAddr[idx];
        len      = opLen[idx];
        isFetch  = (opCode[idx] == 0) || (opCode[idx] == 3);
        isData   = (opCode[idx] != 0);
        isStore  = (opCode[idx] == 2);
        if (isStore) begin
            writeModel(addr, len, opData[idx]);
        end
        fetchModel = readModel(addr, 4);
        dataModel  = readModel(addr, len);
        // file values against the model
        if (opCode[idx] == 0) check("expected fetch word", opExpect[idx], fetchModel);
        if (opCode[idx] == 3) check("expected fetch word", opData[idx], fetchModel);
        if (isData && !isStore) check("expected load value", opExpect[idx], dataModel);
        // every fourth op runs with a stall
        stallLen = (idx % 4 == 3) ? 1 + int'($unsigned($random(seed)) % 4) : 0;
        gap      = int'($unsigned($random(seed)) % 4);
        repeat (gap) @(negedge clk);
        fetchReq  = isFetch;
        fetchAddr = memBusPkg::addrT'(addr);
        dataReq   = isData;
        dataWrite = isStore;
        dataLen   = memBusPkg::lenT'(len);
        dataAddr  = memBusPkg::addrT'(addr);
        dataWdata = opData[idx];
        @(negedge clk);
        fetchReq = 1'b0;
        dataReq  = 1'b0;
        // a pending request makes the path busy
        check("busy", 32'(busy), 32'd1);
        elapsed  = 0;
        fetchAt  = -1;
        dataAt   = -1;
        while ((isFetch && fetchAt < 0) || (isData && dataAt < 0)) begin
            @(negedge clk);
            elapsed++;
            if (fetchDone) begin
                if (!isFetch || fetchAt >= 0) begin
                    reportFailure("fetchDone pulsed with no fetch outstanding");
                end else begin
                    fetchAt = elapsed;
                    check("fetchInst", fetchInst, fetchModel);
                end
            end
            if (dataDone) begin
                if (!isData || dataAt >= 0) begin
                    reportFailure("dataDone pulsed with no data access outstanding");
                end else begin
                    dataAt = elapsed;
                    if (!isStore) check("dataRdata", dataRdata, dataModel);
                end
            end
            if (stallLen > 0 && elapsed == 2) ioBufferFull = 1'b1;
            if (stallLen > 0 && elapsed == 2 + stallLen) ioBufferFull = 1'b0;
        end
        ioBufferFull = 1'b0;
        nominal = isStore ? len + 2 : (isData ? len + 3 : 7);
        if (opCode[idx] == 3) begin
            if (fetchAt <= dataAt) reportFailure("fetchDone did not come after dataDone");
        end else if (stallLen == 0) begin
            check("done latency", elapsed, nominal);
        end else if (elapsed <= nominal) begin
            reportFailure("holding ioBufferFull did not delay the done pulse");
        end
        // done is a single pulse and the path drains
        @(negedge clk);
        check("fetchDone", 32'(fetchDone), 32'd0);
        check("dataDone", 32'(dataDone), 32'd0);
        check("busy", 32'(busy), 32'd0);
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        fetchReq     = 1'b0;
        fetchAddr    = '0;
        dataReq      = 1'b0;
        dataWrite    = 1'b0;
        dataLen      = '0;
        dataAddr     = '0;
        dataWdata    = '0;
        ioBufferFull = 1'b0;
        for (int i = 0; i < `MEM_DEPTH; i++) begin
            modelMem[i] = '0;
        end
        loadStimulus();
        if (opCode.size() == 0) reportFailure("the stimulus file holds no operations");
        timeoutLimit = cyclesPerOp * opCode.size() + resetCycles;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // quiet until the first request
        repeat (3) begin
            @(negedge clk);
            check("fetchDone", 32'(fetchDone), 32'd0);
            check("dataDone", 32'(dataDone), 32'd0);
            check("busy", 32'(busy), 32'd0);
        end
        for (int i = 0; i < opCode.size(); i++) begin
            runOp(i);
        end
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/memSubsystem.sv
`default_nettype none
`timescale 1ns/100ps

`include "mem_consts.svh"

module memSubsystem (
    input  logic             clk,
    input  logic             rst,
    input  logic             fetchReq,
    input  memBusPkg::addrT  fetchAddr,
    input  logic             dataReq,
    input  logic             dataWrite,
    input  memBusPkg::lenT   dataLen,
    input  memBusPkg::addrT  dataAddr,
    input  memBusPkg::wordT  dataWdata,
    input  logic             ioBufferFull,
    output logic             fetchDone,
    output memBusPkg::wordT  fetchInst,
    output logic             dataDone,
    output memBusPkg::wordT  dataRdata,
    output logic             busy
);

    logic                            grant;
    memCtrlPkg::sourceT              grantSource;
    memBusPkg::accessKindT           grantKind;
    memBusPkg::addrT                 grantAddr;
    memBusPkg::lenT                  grantLen;
    memBusPkg::wordT                 grantWdata;
    logic                            seqIdle;
    logic                            ramEn;
    logic                            ramWrite;
    memBusPkg::addrT                 ramAddr;
    memBusPkg::byteT                 ramWdata;
    memBusPkg::byteT                 ramRdata;
    logic                            tagValid;
    logic [$clog2(`WORD_BYTES)-1:0]  tagIndex;
    logic                            tagLast;
    memCtrlPkg::sourceT              tagSource;
    logic                            writeDone;
    memCtrlPkg::sourceT              writeSource;

    requestArbiter i_requestArbiter (
        .clk(clk), .rst(rst),
        .fetchReq(fetchReq), .fetchAddr(fetchAddr),
        .dataReq(dataReq), .dataWrite(dataWrite), .dataLen(dataLen),
        .dataAddr(dataAddr), .dataWdata(dataWdata),
        .seqIdle(seqIdle),
        .grant(grant), .grantSource(grantSource), .grantKind(grantKind),
        .grantAddr(grantAddr), .grantLen(grantLen), .grantWdata(grantWdata),
        .busy(busy)
    );

    byteSequencer i_byteSequencer (
        .clk(clk), .rst(rst), .ioBufferFull(ioBufferFull),
        .grant(grant), .grantSource(grantSource), .grantKind(grantKind),
        .grantAddr(grantAddr), .grantLen(grantLen), .grantWdata(grantWdata),
        .seqIdle(seqIdle),
        .ramEn(ramEn), .ramWrite(ramWrite), .ramAddr(ramAddr), .ramWdata(ramWdata),
        .tagValid(tagValid), .tagIndex(tagIndex), .tagLast(tagLast),
        .tagSource(tagSource),
        .writeDone(writeDone), .writeSource(writeSource)
    );

    byteRam i_byteRam (
        .clk(clk), .ramEn(ramEn), .ramWrite(ramWrite),
        .ramAddr(ramAddr), .ramWdata(ramWdata), .ramRdata(ramRdata)
    );

    wordAssembler i_wordAssembler (
        .clk(clk), .rst(rst),
        .tagValid(tagValid), .tagIndex(tagIndex), .tagLast(tagLast),
        .tagSource(tagSource), .ramRdata(ramRdata),
        .writeDone(writeDone), .writeSource(writeSource),
        .fetchDone(fetchDone), .fetchInst(fetchInst),
        .dataDone(dataDone), .dataRdata(dataRdata)
    );

endmodule

`default_nettype wire

//--- design/wordAssembler.sv
`default_nettype none
`timescale 1ns/100ps

`include "mem_consts.svh"

module wordAssembler (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            tagValid,
    input  logic [$clog2(`WORD_BYTES)-1:0]  tagIndex,
    input  logic                            tagLast,
    input  memCtrlPkg::sourceT              tagSource,
    input  memBusPkg::byteT                 ramRdata,
    input  logic                            writeDone,
    input  memCtrlPkg::sourceT              writeSource,
    output logic                            fetchDone,
    output memBusPkg::wordT                 fetchInst,
    output logic                            dataDone,
    output memBusPkg::wordT                 dataRdata
);

    memBusPkg::wordT wordQ;
    memBusPkg::wordT nextWord;
    logic            fetchDoneQ;
    logic            dataDoneQ;

    // byte 0 starts a new access, so stale upper bytes go to zero
    always_comb begin
        nextWord = (tagIndex == '0) ? '0 : wordQ;
        nextWord[8*tagIndex +: 8] = ramRdata;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetchDoneQ <= 1'b0;
            dataDoneQ  <= 1'b0;
        end else begin
            fetchDoneQ <= tagValid && tagLast && (tagSource == memCtrlPkg::fetch);
            dataDoneQ  <= tagValid && tagLast && (tagSource == memCtrlPkg::data);
        end
    end

    always_ff @(posedge clk) begin
        if (tagValid) begin
            wordQ <= nextWord;
            if (tagLast) begin
                if (tagSource == memCtrlPkg::fetch) begin
                    fetchInst <= nextWord;
                end else begin
                    dataRdata <= nextWord;
                end
            end
        end
    end

    assign fetchDone = fetchDoneQ;
    // store completion goes straight out
    assign dataDone  = dataDoneQ || (writeDone && writeSource == memCtrlPkg::data);

    assert property (@(posedge clk) disable iff (rst)
        !(fetchDone && dataDone));

endmodule

`default_nettype wire

//--- design/byteRam.sv
`default_nettype none
`timescale 1ns/100ps

`include "mem_consts.svh"

module byteRam (
    input  logic             clk,
    input  logic             ramEn,
    input  logic             ramWrite,
    input  memBusPkg::addrT  ramAddr,
    input  memBusPkg::byteT  ramWdata,
    output memBusPkg::byteT  ramRdata
);

    memBusPkg::byteT mem [`MEM_DEPTH];

    // simulation starts from a cleared memory
    initial begin
        for (int i = 0; i < `MEM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (ramEn) begin
            if (ramWrite) begin
                mem[ramAddr] <= ramWdata;
            end else begin
                ramRdata <= mem[ramAddr];
            end
        end
    end

endmodule

`default_nettype wire

//--- design/byteSequencer.sv
`default_nettype none
`timescale 1ns/100ps

`include "mem_consts.svh"

module byteSequencer (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            ioBufferFull,
    input  logic                            grant,
    input  memCtrlPkg::sourceT              grantSource,
    input  memBusPkg::accessKindT           grantKind,
    input  memBusPkg::addrT                 grantAddr,
    input  memBusPkg::lenT                  grantLen,
    input  memBusPkg::wordT                 grantWdata,
    output logic                            seqIdle,
    output logic                            ramEn,
    output logic                            ramWrite,
    output memBusPkg::addrT                 ramAddr,
    output memBusPkg::byteT                 ramWdata,
    output logic                            tagValid,
    output logic [$clog2(`WORD_BYTES)-1:0]  tagIndex,
    output logic                            tagLast,
    output memCtrlPkg::sourceT              tagSource,
    output logic                            writeDone,
    output memCtrlPkg::sourceT              writeSource
);

    memCtrlPkg::seqStateT                state;
    memCtrlPkg::sourceT                  sourceQ;
    memBusPkg::accessKindT               kindQ;
    memBusPkg::addrT                     baseAddrQ;
    memBusPkg::lenT                      lenQ;
    memBusPkg::wordT                     wdataQ;
    memBusPkg::lenT                      idx;
    logic [$clog2(`WORD_BYTES)-1:0]      byteIdx;
    logic                                issueNow;
    logic                                lastByte;

    assign seqIdle  = (state == memCtrlPkg::idle);
    assign issueNow = (state == memCtrlPkg::issue) && !ioBufferFull;
    assign lastByte = (idx == lenQ - 3'd1);
    assign byteIdx  = idx[$clog2(`WORD_BYTES)-1:0];

    assign ramEn    = issueNow;
    assign ramWrite = issueNow && (kindQ == memBusPkg::write);
    assign ramAddr  = baseAddrQ + memBusPkg::addrT'(idx);
    assign ramWdata = wdataQ[8*byteIdx +: 8];

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= memCtrlPkg::idle;
            idx       <= '0;
            tagValid  <= 1'b0;
            writeDone <= 1'b0;
        end else begin
            // tag lines up with the read data one cycle later
            tagValid  <= issueNow && (kindQ == memBusPkg::read);
            writeDone <= issueNow && (kindQ == memBusPkg::write) && lastByte;
            case (state)
                memCtrlPkg::idle: begin
                    if (grant) begin
                        state <= memCtrlPkg::issue;
                        idx   <= '0;
                    end
                end
                memCtrlPkg::issue: begin
                    if (ioBufferFull) begin
                        state <= memCtrlPkg::stalled;
                    end else begin
                        idx <= idx + 3'd1;
                        if (lastByte) begin
                            state <= memCtrlPkg::idle;
                        end
                    end
                end
                memCtrlPkg::stalled: begin
                    // index held, resume once the buffer drains
                    if (!ioBufferFull) begin
                        state <= memCtrlPkg::issue;
                    end
                end
                default: begin
                    state <= memCtrlPkg::idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (grant && seqIdle) begin
            sourceQ   <= grantSource;
            kindQ     <= grantKind;
            baseAddrQ <= grantAddr;
            lenQ      <= grantLen;
            wdataQ    <= grantWdata;
        end
        tagIndex    <= byteIdx;
        tagLast     <= lastByte;
        tagSource   <= sourceQ;
        writeSource <= sourceQ;
    end

    assert property (@(posedge clk) disable iff (rst)
        grant |-> (grantLen == 3'd1 || grantLen == 3'd2 || grantLen == 3'd4));

    // arbiter must wait for idle
    assert property (@(posedge clk) disable iff (rst)
        grant |-> seqIdle);

endmodule

`default_nettype wire

//--- design/requestArbiter.sv
`default_nettype none
`timescale 1ns/100ps

`include "mem_consts.svh"

module requestArbiter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetchReq,
    input  memBusPkg::addrT        fetchAddr,
    input  logic                   dataReq,
    input  logic                   dataWrite,
    input  memBusPkg::lenT         dataLen,
    input  memBusPkg::addrT        dataAddr,
    input  memBusPkg::wordT        dataWdata,
    input  logic                   seqIdle,
    output logic                   grant,
    output memCtrlPkg::sourceT     grantSource,
    output memBusPkg::accessKindT  grantKind,
    output memBusPkg::addrT        grantAddr,
    output memBusPkg::lenT         grantLen,
    output memBusPkg::wordT        grantWdata,
    output logic                   busy
);

    logic                  fetchPending;
    logic                  dataPending;
    memBusPkg::addrT       fetchAddrQ;
    memBusPkg::accessKindT dataKindQ;
    memBusPkg::lenT        dataLenQ;
    memBusPkg::addrT       dataAddrQ;
    memBusPkg::wordT       dataWdataQ;
    logic                  canGrant;
    logic                  grantData;
    logic                  grantFetch;

    // the cycle after a grant the sequencer has not left idle yet
    assign canGrant   = seqIdle && !grant;
    assign grantData  = canGrant && dataPending;
    assign grantFetch = canGrant && !dataPending && fetchPending;

    always_ff @(posedge clk) begin
        if (rst) begin
            fetchPending <= 1'b0;
            dataPending  <= 1'b0;
            grant        <= 1'b0;
        end else begin
            grant <= grantData || grantFetch;
            if (grantData) begin
                dataPending <= 1'b0;
            end
            if (grantFetch) begin
                fetchPending <= 1'b0;
            end
            // requester waits for done, so no clash with the clears above
            if (fetchReq) begin
                fetchPending <= 1'b1;
            end
            if (dataReq) begin
                dataPending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetchReq) begin
            fetchAddrQ <= fetchAddr;
        end
        if (dataReq) begin
            dataKindQ  <= dataWrite ? memBusPkg::write : memBusPkg::read;
            dataLenQ   <= dataLen;
            dataAddrQ  <= dataAddr;
            dataWdataQ <= dataWdata;
        end
        if (grantData) begin
            grantSource <= memCtrlPkg::data;
            grantKind   <= dataKindQ;
            grantAddr   <= dataAddrQ;
            grantLen    <= dataLenQ;
            grantWdata  <= dataWdataQ;
        end else if (grantFetch) begin
            grantSource <= memCtrlPkg::fetch;
            grantKind   <= memBusPkg::read;
            grantAddr   <= fetchAddrQ;
            grantLen    <= memBusPkg::lenT'(`WORD_BYTES);
            grantWdata  <= '0;
        end
    end

    assign busy = fetchPending || dataPending || grant || !seqIdle;

    // one outstanding request per requester
    assert property (@(posedge clk) disable iff (rst)
        !((fetchReq && fetchPending) || (dataReq && dataPending)));

endmodule

`default_nettype wire

//--- design/memCtrlPkg.sv
`default_nettype none

package memCtrlPkg;

    // owner of an access
    typedef enum logic {
        fetch,
        data
    } sourceT;

    // sequencer states
    typedef enum logic [1:0] {
        idle,
        issue,
        stalled
    } seqStateT;

endpackage

`default_nettype wire

//--- design/memBusPkg.sv
`default_nettype none

`include "mem_consts.svh"

package memBusPkg;

    // byte address into main memory
    typedef logic [`MEM_ADDR_WIDTH-1:0] addrT;

    // one memory datum
    typedef logic [7:0] byteT;

    // instruction or data word, little endian in memory
    typedef logic [8*`WORD_BYTES-1:0] wordT;

    // byte count of one access, 1, 2 or 4
    typedef logic [2:0] lenT;

    typedef enum logic {
        read,
        write
    } accessKindT;

endpackage

`default_nettype wire

//--- include/mem_consts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// byte address width of main memory
`define MEM_ADDR_WIDTH 17

// bytes in main memory
`define MEM_DEPTH (1 << `MEM_ADDR_WIDTH)

// bytes per instruction or data word
`define WORD_BYTES 4

`endif
